// File: src/harness_pkg.sv
// ----------------------------------------------------------------------
// Shared definitions for the simulation memory harness
// Memory map, bus widths, target encoding and the request address view
// ----------------------------------------------------------------------

`default_nettype none

package harness_pkg;

  // --------------------------------------------------------------------
  // Bus widths
  // --------------------------------------------------------------------
  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 64;
  localparam int unsigned BeWidth   = DataWidth / 8;
  localparam int unsigned IdxWidth  = 13;  // Word index field of the address
  localparam int unsigned NumHarts  = 2;

  // --------------------------------------------------------------------
  // Memory map
  // --------------------------------------------------------------------
  localparam int unsigned RomWords     = 512;
  localparam int unsigned DramWords    = 1024;
  localparam int unsigned RomIdxWidth  = $clog2(RomWords);
  localparam int unsigned DramIdxWidth = $clog2(DramWords);

  localparam logic [3:0] RomRegion  = 4'h0;
  localparam logic [3:0] GpioRegion = 4'h4;  // No device, answers with error
  localparam logic [3:0] DramRegion = 4'h8;

  // Last DRAM word, written by software to end the run
  localparam logic [AddrWidth-1:0] ExitAddr = 32'h8000_1FF8;

  localparam logic [31:0] RomSignature = 32'hB007_C0DE;

  // Window after power-on in which harts may not be halted
  localparam int unsigned DebugDelayCycles = 50;
  localparam int unsigned DbgCntWidth      = $clog2(DebugDelayCycles + 1);

  // --------------------------------------------------------------------
  // Types
  // --------------------------------------------------------------------
  typedef enum logic [1:0] {
    TgtRom  = 2'd0,
    TgtDram = 2'd1,
    TgtErr  = 2'd2
  } target_e;

  typedef struct packed {
    logic [3:0]          region;
    logic [11:0]         rsvd;      // Ignored by the decoder
    logic [IdxWidth-1:0] word_idx;
    logic [2:0]          byte_off;
  } addr_fields_t;

  // Raw word for exact compares, fields for region decode
  typedef union packed {
    logic [AddrWidth-1:0] raw;
    addr_fields_t         fields;
  } addr_u;

  typedef logic [DataWidth-1:0] word_t;
  typedef logic [BeWidth-1:0]   be_t;

endpackage

`default_nettype wire

// File: src/mem_req_if.sv
// ----------------------------------------------------------------------
// Decoded request bus from the address decoder to the memory targets
// ----------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

interface mem_req_if;
  import harness_pkg::*;

  logic    req;
  logic    we;
  addr_u   addr;
  be_t     be;
  word_t   wdata;
  target_e sel;    // Target chosen by the decoder

  modport decoder (
    output req, we, addr, be, wdata, sel
  );

  modport target (
    input req, we, addr, be, wdata, sel
  );

  modport monitor (
    input req, we, addr, be, wdata, sel
  );

endinterface

`default_nettype wire

// File: src/debug_reset_ctrl.sv
// ----------------------------------------------------------------------
// Bus-side reset generation and gating of per-hart debug requests
// ----------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module debug_reset_ctrl (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic                             ndmreset_i,
  input  logic                             debug_enable_i,
  input  logic [harness_pkg::NumHarts-1:0] debug_req_i,
  output logic                             sys_rst_no,
  output logic [harness_pkg::NumHarts-1:0] debug_req_o
);
  import harness_pkg::*;

  logic                   rst_comb_n;
  logic [1:0]             sync_q;
  logic [DbgCntWidth-1:0] dly_cnt_q;

  // Either power-on reset or a debug-module reset clears the bus side
  assign rst_comb_n = rst_ni & ~ndmreset_i;

  // Async assert, release after two edges
  always_ff @(posedge clk_i or negedge rst_comb_n) begin
    if (!rst_comb_n) begin
      sync_q <= '0;
    end else begin
      sync_q <= {sync_q[0], 1'b1};
    end
  end

  assign sys_rst_no = sync_q[1];

  // --------------------------------------------------------------------
  // Debug request delay
  // --------------------------------------------------------------------
  // Only power-on reset restarts the window
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      dly_cnt_q <= DbgCntWidth'(DebugDelayCycles);
    end else if (dly_cnt_q != '0) begin
      dly_cnt_q <= dly_cnt_q - 1'b1;
    end
  end

  assign debug_req_o = (dly_cnt_q == '0 && debug_enable_i) ? debug_req_i : '0;

endmodule

`default_nettype wire

// File: src/addr_decode.sv
// ----------------------------------------------------------------------
// Host request decoder
// Picks ROM, DRAM or error target from region nibble and word range
// ----------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module addr_decode (
  input  logic                              req_i,
  input  logic                              we_i,
  input  logic [harness_pkg::AddrWidth-1:0] addr_i,
  input  harness_pkg::be_t                  be_i,
  input  harness_pkg::word_t                wdata_i,
  mem_req_if.decoder                        bus
);
  import harness_pkg::*;

  addr_u   addr;
  target_e sel;
  logic    rom_in_range;
  logic    dram_in_range;

  assign addr = addr_i;

  assign rom_in_range  = addr.fields.word_idx < IdxWidth'(RomWords);
  assign dram_in_range = addr.fields.word_idx < IdxWidth'(DramWords);

  // --------------------------------------------------------------------
  // Target select
  // --------------------------------------------------------------------
  always_comb begin
    sel = TgtErr;  // Unknown regions fall through to error
    case (addr.fields.region)
      RomRegion: begin
        // ROM is read-only, a write is answered as error
        if (rom_in_range && !we_i) begin
          sel = TgtRom;
        end
      end
      DramRegion: begin
        if (dram_in_range) begin
          sel = TgtDram;
        end
      end
      GpioRegion: sel = TgtErr;  // GPIO not modelled
      default:    sel = TgtErr;
    endcase
  end

  // Request fields pass straight through
  assign bus.req   = req_i;
  assign bus.we    = we_i;
  assign bus.addr  = addr;
  assign bus.be    = be_i;
  assign bus.wdata = wdata_i;
  assign bus.sel   = sel;

endmodule

`default_nettype wire

// File: src/boot_rom.sv
// ----------------------------------------------------------------------
// Boot ROM with contents built from a fixed rule
// Each word holds the signature and its own word index
// ----------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module boot_rom (
  input  logic               clk_i,
  mem_req_if.target          bus,
  output harness_pkg::word_t rdata_o
);
  import harness_pkg::*;

  word_t                  rom_mem [RomWords];
  logic [RomIdxWidth-1:0] rom_idx;
  logic                   rd_en;
  word_t                  rdata_q;

  // --------------------------------------------------------------------
  // Contents
  // --------------------------------------------------------------------
  for (genvar i = 0; i < RomWords; i++) begin : gen_rom_word
    assign rom_mem[i] = {RomSignature, 32'(i)};
  end

  // Decoder has already range-checked the index
  assign rom_idx = bus.addr.fields.word_idx[RomIdxWidth-1:0];
  assign rd_en   = bus.req && !bus.we && (bus.sel == TgtRom);

  always_ff @(posedge clk_i) begin
    if (rd_en) begin
      rdata_q <= rom_mem[rom_idx];
    end
  end

  assign rdata_o = rdata_q;

endmodule

`default_nettype wire

// File: src/sim_sram.sv
// ----------------------------------------------------------------------
// DRAM model with byte-enable writes and registered reads
// Contents survive any reset
// ----------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module sim_sram (
  input  logic               clk_i,
  mem_req_if.target          bus,
  output harness_pkg::word_t rdata_o
);
  import harness_pkg::*;

  word_t                   mem [DramWords];
  logic [DramIdxWidth-1:0] mem_idx;
  logic                    sel_hit;
  word_t                   rdata_q;

  assign mem_idx = bus.addr.fields.word_idx[DramIdxWidth-1:0];
  assign sel_hit = bus.req && (bus.sel == TgtDram);

  // --------------------------------------------------------------------
  // Storage
  // --------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (sel_hit) begin
      if (bus.we) begin
        for (int b = 0; b < BeWidth; b++) begin
          if (bus.be[b]) begin
            mem[mem_idx][b*8 +: 8] <= bus.wdata[b*8 +: 8];
          end
        end
      end else begin
        rdata_q <= mem[mem_idx];
      end
    end
  end

  assign rdata_o = rdata_q;

endmodule

`default_nettype wire

// File: src/resp_mux.sv
// ----------------------------------------------------------------------
// Response path
// Returns target read data or error one cycle later, flags exit writes
// ----------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module resp_mux (
  input  logic               clk_i,
  input  logic               rst_ni,
  mem_req_if.monitor         bus,
  input  harness_pkg::word_t rom_rdata_i,
  input  harness_pkg::word_t sram_rdata_i,
  output logic               rsp_valid_o,
  output harness_pkg::word_t rsp_rdata_o,
  output logic               rsp_err_o,
  output logic [31:0]        exit_o
);
  import harness_pkg::*;

  logic        valid_q;
  logic        we_q;
  target_e     sel_q;
  logic        exit_hit;
  logic [31:0] exit_q;

  // Full address compare, byte offset included
  assign exit_hit = bus.req && bus.we && (bus.sel == TgtDram) &&
                    (bus.addr.raw == ExitAddr);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
      we_q    <= 1'b0;
      sel_q   <= TgtErr;
      exit_q  <= '0;
    end else begin
      valid_q <= bus.req;
      we_q    <= bus.we;
      sel_q   <= bus.sel;
      exit_q  <= exit_hit ? bus.wdata[31:0] : '0;  // One-cycle pulse
    end
  end

  // --------------------------------------------------------------------
  // Response
  // --------------------------------------------------------------------
  always_comb begin
    rsp_rdata_o = '0;  // Writes and errors return zero
    if (valid_q && !we_q) begin
      case (sel_q)
        TgtRom:  rsp_rdata_o = rom_rdata_i;
        TgtDram: rsp_rdata_o = sram_rdata_i;
        default: rsp_rdata_o = '0;
      endcase
    end
  end

  assign rsp_valid_o = valid_q;
  assign rsp_err_o   = valid_q && (sel_q == TgtErr);
  assign exit_o      = exit_q;

endmodule

`default_nettype wire

// File: src/harness_top.sv
// ----------------------------------------------------------------------
// Memory harness top level
// Host request port onto boot ROM, DRAM model and error region
// ----------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module harness_top (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  logic                                 ndmreset_i,
  input  logic                                 debug_enable_i,
  input  logic [harness_pkg::NumHarts-1:0]     debug_req_i,
  input  logic                                 req_i,
  input  logic                                 we_i,
  input  logic [harness_pkg::AddrWidth-1:0]    addr_i,
  input  harness_pkg::be_t                     be_i,
  input  harness_pkg::word_t                   wdata_i,
  output logic                                 rsp_valid_o,
  output logic                                 rsp_err_o,
  output harness_pkg::word_t                   rsp_rdata_o,
  output logic [31:0]                          exit_o,
  output logic [harness_pkg::NumHarts-1:0]     debug_req_o
);
  import harness_pkg::*;

  logic  sys_rst_n;   // Bus-side reset, includes ndmreset
  word_t rom_rdata;
  word_t sram_rdata;

  mem_req_if bus ();

  // --------------------------------------------------------------------
  // Reset and debug
  // --------------------------------------------------------------------
  debug_reset_ctrl i_debug_reset_ctrl (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .ndmreset_i     ( ndmreset_i     ),
    .debug_enable_i ( debug_enable_i ),
    .debug_req_i    ( debug_req_i    ),
    .sys_rst_no     ( sys_rst_n      ),
    .debug_req_o    ( debug_req_o    )
  );

  // --------------------------------------------------------------------
  // Request path
  // --------------------------------------------------------------------
  addr_decode i_addr_decode (
    .req_i   ( req_i   ),
    .we_i    ( we_i    ),
    .addr_i  ( addr_i  ),
    .be_i    ( be_i    ),
    .wdata_i ( wdata_i ),
    .bus     ( bus     )
  );

  boot_rom i_boot_rom (
    .clk_i   ( clk_i     ),
    .bus     ( bus       ),
    .rdata_o ( rom_rdata )
  );

  sim_sram i_sim_sram (
    .clk_i   ( clk_i      ),
    .bus     ( bus        ),
    .rdata_o ( sram_rdata )
  );

  resp_mux i_resp_mux (
    .clk_i        ( clk_i       ),
    .rst_ni       ( sys_rst_n   ),
    .bus          ( bus         ),
    .rom_rdata_i  ( rom_rdata   ),
    .sram_rdata_i ( sram_rdata  ),
    .rsp_valid_o  ( rsp_valid_o ),
    .rsp_rdata_o  ( rsp_rdata_o ),
    .rsp_err_o    ( rsp_err_o   ),
    .exit_o       ( exit_o      )
  );

endmodule

`default_nettype wire

// File: verif/harness_tb.sv
// ----------------------------------------------------------------------
// Directed testbench for the memory harness
// ----------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module harness_tb;
  import harness_pkg::*;

  localparam int TimeoutCycles = 2000;  // Ample margin over the full test run

  logic        clk_i = 1'b0;
  logic        rst_ni;
  logic        ndmreset_i;
  logic        debug_enable_i;
  logic        req_i;
  logic        we_i;
  logic [1:0]  debug_req_i;
  logic [31:0] addr_i;
  logic [7:0]  be_i;
  logic [63:0] wdata_i;
  logic        rsp_valid_o;
  logic        rsp_err_o;
  logic [63:0] rsp_rdata_o;
  logic [31:0] exit_o;
  logic [1:0]  debug_req_o;

  logic [63:0] dram_model [1024];  // Expected DRAM contents
  logic [31:0] lfsr_q = 32'hbac6_a877;
  string       cur_test;
  int          err_cnt = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  int          cycle_cnt = 0;

  harness_top dut0 (.*);

  always #10 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt >= TimeoutCycles) begin
      $display("Timeout: run did not finish within %0d cycles", TimeoutCycles);
      $display("*** FAILED ***");
      $finish;
    end
  end

  // ----------------------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------------------
  // Fibonacci LFSR, taps 32 22 2 1, one step per bit
  function automatic logic [63:0] take_bits(input int n);
    logic [63:0] val;
    logic        fb;
    val = '0;
    for (int i = 0; i < n; i++) begin
      fb    = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      val   = {val[62:0], fb};
    end
    return val;
  endfunction

  function automatic logic [31:0] dram_addr(input int idx);
    return 32'h8000_0000 + 32'(idx) * 8;
  endfunction

  function automatic void model_write(input int idx, input logic [7:0] be,
                                      input logic [63:0] data);
    for (int b = 0; b < 8; b++) begin
      if (be[b]) dram_model[idx][b*8 +: 8] = data[b*8 +: 8];
    end
  endfunction

  task automatic step();
    @(posedge clk_i);
    #2;  // Outputs settled, inputs change here
  endtask

  task automatic check_val(input string field, input logic [63:0] exp,
                           input logic [63:0] act);
    assert (act === exp) else begin
      $display("Error %s %s: expected %h, actual %h", cur_test, field, exp, act);
      err_cnt++;
    end
  endtask

  task automatic go_idle();
    req_i = 1'b0;
    we_i  = 1'b0;
  endtask

  // One request, response checked in the following cycle
  task automatic access(input string field, input logic we, input logic [31:0] addr,
                        input logic [7:0] be, input logic [63:0] wdata,
                        input logic exp_err, input logic [63:0] exp_data);
    req_i   = 1'b1;
    we_i    = we;
    addr_i  = addr;
    be_i    = be;
    wdata_i = wdata;
    step();
    assert (rsp_valid_o === 1'b1) else begin
      $display("%s %s: no response in the cycle after the request", cur_test, field);
      err_cnt++;
    end
    check_val({field, " err"}, 64'(exp_err), 64'(rsp_err_o));
    check_val({field, " rdata"}, exp_data, rsp_rdata_o);
  endtask

  task automatic end_test(input int err_start);
    tests_run++;
    if (err_cnt == err_start) begin
      $display("Test %s: ok", cur_test);
    end else begin
      tests_failed++;
      $display("Test %s: %0d errors", cur_test, err_cnt - err_start);
    end
  endtask

  // ----------------------------------------------------------------------
  // Tests
  // ----------------------------------------------------------------------
  // Starts right at reset release
  task automatic test_debug_gating();
    int e0;
    e0 = err_cnt;
    cur_test = "debug_gating";
    check_val("reset valid", 64'd0, 64'(rsp_valid_o));
    check_val("reset err", 64'd0, 64'(rsp_err_o));
    check_val("reset exit", 64'd0, 64'(exit_o));
    for (int k = 0; k < DebugDelayCycles; k++) begin
      check_val("blocked", 64'd0, 64'(debug_req_o));
      step();
    end
    check_val("open", 64'h3, 64'(debug_req_o));
    debug_req_i = 2'b10;
    step();
    check_val("follow", 64'h2, 64'(debug_req_o));
    debug_enable_i = 1'b0;
    step();
    check_val("disabled", 64'd0, 64'(debug_req_o));
    debug_enable_i = 1'b1;
    debug_req_i    = 2'b11;
    end_test(e0);
  endtask

  task automatic test_rom_reads();
    int e0;
    int idx_list[5] = '{0, 1, 5, 255, 511};
    e0 = err_cnt;
    cur_test = "rom_reads";
    foreach (idx_list[i]) begin
      access("read", 1'b0, 32'(idx_list[i]) * 8, 8'h00, 64'd0, 1'b0,
             {32'hB007_C0DE, 32'(idx_list[i])});
    end
    go_idle();
    end_test(e0);
  endtask

  task automatic test_dram_writes();
    int          e0;
    logic [63:0] d;
    logic [7:0]  be;
    e0 = err_cnt;
    cur_test = "dram_writes";
    for (int i = 0; i < 8; i++) begin
      d = take_bits(64);
      access("init", 1'b1, dram_addr(100 + i), 8'hff, d, 1'b0, 64'd0);
      model_write(100 + i, 8'hff, d);
    end
    for (int i = 0; i < 8; i++) begin
      d  = take_bits(64);
      be = 8'(take_bits(8));
      access("merge", 1'b1, dram_addr(100 + i), be, d, 1'b0, 64'd0);
      model_write(100 + i, be, d);
    end
    for (int i = 0; i < 8; i++) begin
      access("read", 1'b0, dram_addr(100 + i), 8'h00, 64'd0, 1'b0, dram_model[100 + i]);
    end
    go_idle();
    end_test(e0);
  endtask

  task automatic test_error_rsp();
    int e0;
    e0 = err_cnt;
    cur_test = "error_rsp";
    access("gpio", 1'b0, 32'h4000_0010, 8'h00, 64'd0, 1'b1, 64'd0);
    access("unknown region", 1'b0, 32'hC000_0000, 8'h00, 64'd0, 1'b1, 64'd0);
    access("rom range", 1'b0, 32'h0000_1000, 8'h00, 64'd0, 1'b1, 64'd0);
    access("dram range", 1'b0, dram_addr(1024), 8'h00, 64'd0, 1'b1, 64'd0);
    access("rom write", 1'b1, 32'h0000_0008, 8'hff, take_bits(64), 1'b1, 64'd0);
    // Index 1124 would alias word 100 if the write got through
    access("dram range write", 1'b1, dram_addr(1124), 8'hff, take_bits(64), 1'b1, 64'd0);
    access("after bad write", 1'b0, dram_addr(100), 8'h00, 64'd0, 1'b0, dram_model[100]);
    access("rom after write", 1'b0, 32'h0000_0008, 8'h00, 64'd0, 1'b0,
           {32'hB007_C0DE, 32'd1});
    go_idle();
    end_test(e0);
  endtask

  task automatic test_exit();
    int          e0;
    logic [63:0] d;
    e0 = err_cnt;
    cur_test = "exit";
    d = take_bits(64);
    access("exit write", 1'b1, 32'h8000_1FF8, 8'hff, d, 1'b0, 64'd0);
    model_write(1023, 8'hff, d);
    check_val("exit_o", 64'(d[31:0]), 64'(exit_o));
    go_idle();
    step();
    check_val("exit_o after", 64'd0, 64'(exit_o));
    d = take_bits(64);
    access("neighbour write", 1'b1, 32'h8000_1FF0, 8'hff, d, 1'b0, 64'd0);
    model_write(1022, 8'hff, d);
    check_val("exit_o neighbour", 64'd0, 64'(exit_o));
    go_idle();
    end_test(e0);
  endtask

  task automatic test_ndmreset();
    int e0;
    e0 = err_cnt;
    cur_test = "ndmreset";
    ndmreset_i = 1'b1;
    req_i      = 1'b1;
    we_i       = 1'b0;
    for (int i = 0; i < 4; i++) begin
      addr_i = dram_addr(100 + i);
      step();
      check_val("valid in reset", 64'd0, 64'(rsp_valid_o));
    end
    check_val("debug in reset", 64'h3, 64'(debug_req_o));
    go_idle();
    ndmreset_i = 1'b0;
    repeat (3) step();
    for (int i = 0; i < 8; i++) begin
      access("read back", 1'b0, dram_addr(100 + i), 8'h00, 64'd0, 1'b0, dram_model[100 + i]);
    end
    access("exit word", 1'b0, dram_addr(1023), 8'h00, 64'd0, 1'b0, dram_model[1023]);
    go_idle();
    end_test(e0);
  endtask

  // ----------------------------------------------------------------------
  // Sequence
  // ----------------------------------------------------------------------
  initial begin
    rst_ni         = 1'b0;
    ndmreset_i     = 1'b0;
    debug_enable_i = 1'b1;
    debug_req_i    = 2'b11;
    req_i          = 1'b0;
    we_i           = 1'b0;
    addr_i         = '0;
    be_i           = '0;
    wdata_i        = '0;
    repeat (16) @(posedge clk_i);
    #2 rst_ni = 1'b1;
    test_debug_gating();
    test_rom_reads();
    test_dram_writes();
    test_error_rsp();
    test_exit();
    test_ndmreset();
    $display("Tests run %0d, failed %0d, check errors %0d", tests_run, tests_failed, err_cnt);
    if (tests_failed == 0 && err_cnt == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog.f
src/harness_pkg.sv
src/mem_req_if.sv
src/debug_reset_ctrl.sv
src/addr_decode.sv
src/boot_rom.sv
src/sim_sram.sv
src/resp_mux.sv
src/harness_top.sv
verif/harness_tb.sv

// File: Makefile
TOOL       := verilator
SIM_FLAGS  := --binary --timing --assert
LINT_FLAGS := --lint-only --timing
TOP        := harness_tb
RTL_TOP    := harness_top
FILELIST   := verilog.f
BUILD_DIR  := obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q -F '*** PASSED ***'

clean:
	rm -rf $(BUILD_DIR)
